// ==== src/ingress_pkg.sv ====
package ingress_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int data_w = 64;             // input payload word
    localparam int port_w = 4;              // 16 switch ports
    localparam int pri_w  = 3;
    localparam int crc_w  = 32;
    localparam int len_w  = 6;              // payload word count, room for MAX_WORDS + 1

    // fabric word is valid bit, dest, src, then payload
    localparam int out_w = 1 + 2 * port_w + data_w;

    // header word layout
    localparam int hdr_dest_lo = 0;
    localparam int hdr_pri_lo  = port_w;

    ////////////////////////////////////////
    // fabric word field positions
    ////////////////////////////////////////
    localparam int out_valid_bit = 0;
    localparam int out_dest_lo   = 1;
    localparam int out_src_lo    = out_dest_lo + port_w;   // 5
    localparam int out_pri_lo    = out_src_lo + port_w;    // control word only
    localparam int out_crc_lo    = out_pri_lo + pri_w;     // control word only
    localparam int out_pay_lo    = out_src_lo + port_w;    // data word only

    // one entry per committed packet
    typedef struct packed {
        logic [port_w-1:0] dest;
        logic [pri_w-1:0]  pri;
        logic [crc_w-1:0]  crc;
        logic [len_w-1:0]  nwords;
    } desc_t;

endpackage

// ==== src/buf_wr_if.sv ====
interface buf_wr_if;
    import ingress_pkg::*;

    logic              en;          // write one word at tentative pointer
    logic [data_w-1:0] data;
    logic              commit;      // keep everything written so far
    logic              discard;     // roll back to last commit
    logic              full;        // fewer than MAX_WORDS words free
    logic              almost_full;

    modport src (
        output en, data, commit, discard,
        input  full, almost_full
    );

    modport sink (
        input  en, data, commit, discard,
        output full, almost_full
    );

endinterface

// ==== src/crc32_d64.sv ====
module crc32_d64 (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear,
    input  logic                          en,
    input  logic [ingress_pkg::data_w-1:0] data,
    output logic [ingress_pkg::crc_w-1:0]  crc
);
    import ingress_pkg::*;

    localparam logic [crc_w-1:0] poly = 32'hedb88320;   // reflected 0x04c11db7
    localparam logic [crc_w-1:0] seed = '1;

    logic [crc_w-1:0] crc_q;

    // bit serial fold, byte 0 first and lsb first inside each byte,
    // which for a reflected crc is simply bit 0 up to bit 63
    function automatic logic [crc_w-1:0] fold64(
        input logic [crc_w-1:0]  c,
        input logic [data_w-1:0] d
    );
        logic [crc_w-1:0] r;
        r = c;
        for (int i = 0; i < data_w; i++) begin
            r = (r >> 1) ^ ((r[0] ^ d[i]) ? poly : '0);
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            crc_q <= seed;
        end else if (clear) begin
            crc_q <= seed;                  // restart for a new packet
        end else if (en) begin
            crc_q <= fold64(crc_q, data);
        end
    end

    assign crc = ~crc_q;    // final inversion

endmodule

// ==== src/pkt_buffer.sv ====
module pkt_buffer #(
    parameter int BUF_DEPTH = 128,
    parameter int MAX_WORDS = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    buf_wr_if.sink                         wr,
    input  logic                           rd_en,
    output logic [ingress_pkg::data_w-1:0] rd_data
);
    import ingress_pkg::*;

    localparam int aw = $clog2(BUF_DEPTH);

    // occupancy thresholds
    localparam logic [aw:0] full_lvl = (aw + 1)'(BUF_DEPTH - MAX_WORDS);
    localparam logic [aw:0] af_lvl   = (aw + 1)'(BUF_DEPTH * 3 / 4);

    logic [data_w-1:0] mem [BUF_DEPTH];

    logic [aw:0] wr_ptr;    // tentative, moves with every write
    logic [aw:0] wr_cmt;    // end of committed data
    logic [aw:0] rd_ptr;
    logic [aw:0] used;

    ////////////////////////////////////////
    // pointers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            wr_cmt <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr.discard) begin
                wr_ptr <= wr_cmt;           // throw away the partial packet
            end else if (wr.en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (wr.commit) begin
                wr_cmt <= wr_ptr;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // tentative words count as used, so a started packet always fits
    assign used           = wr_ptr - rd_ptr;
    assign wr.full        = used > full_lvl;
    assign wr.almost_full = used >= af_lvl;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr_ptr[aw-1:0]] <= wr.data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr[aw-1:0]];     // one cycle read latency
        end
    end

    // receiver must never run the memory over the unread words
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst)
        wr.en |-> (used != (aw + 1)'(BUF_DEPTH))
    );

    // emitter only reads what the receiver has committed
    a_rd_committed: assert property (
        @(posedge clk) disable iff (!rst)
        rd_en |-> (rd_ptr != wr_cmt)
    );

endmodule

// ==== src/desc_fifo.sv ====
module desc_fifo #(
    parameter int DESC_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  ingress_pkg::desc_t push_desc,
    input  logic               pop,
    output ingress_pkg::desc_t pop_desc,
    output logic               empty
);
    import ingress_pkg::*;

    localparam int aw = $clog2(DESC_DEPTH);

    desc_t       mem [DESC_DEPTH];
    logic [aw:0] wr_ptr;
    logic [aw:0] rd_ptr;
    logic [aw:0] level;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[aw-1:0]] <= push_desc;
        end
    end

    // fall through, head entry is always on the output
    assign pop_desc = mem[rd_ptr[aw-1:0]];
    assign level    = wr_ptr - rd_ptr;
    assign empty    = (level == '0);

    // holds while the source respects full on the packet buffer
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst)
        push |-> (level != (aw + 1)'(DESC_DEPTH))
    );

endmodule

// ==== src/pkt_receiver.sv ====
module pkt_receiver #(
    parameter int MIN_WORDS = 2,
    parameter int MAX_WORDS = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           sop,
    input  logic                           eop,
    input  logic                           vld,
    input  logic [ingress_pkg::data_w-1:0] data,
    buf_wr_if.src                          buf_w,
    output logic                           desc_push,
    output ingress_pkg::desc_t             desc,
    output logic                           drop
);
    import ingress_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_verdict
    } state_t;

    localparam logic [len_w-1:0] min_len = len_w'(MIN_WORDS);
    localparam logic [len_w-1:0] max_len = len_w'(MAX_WORDS);

    state_t            state;
    state_t            state_nxt;
    logic [port_w-1:0] dest_q;
    logic [pri_w-1:0]  pri_q;
    logic [len_w-1:0]  count;       // saturates at MAX_WORDS + 1
    logic              ovf;         // packet began while buffer full
    logic              hdr;
    logic              word;
    logic              len_ok;
    logic              keep;
    logic [crc_w-1:0]  crc;

    assign hdr    = vld && sop;
    assign word   = vld && !sop && (state == st_payload);
    assign len_ok = (count >= min_len) && (count <= max_len);
    assign keep   = (state == st_verdict) && len_ok && !ovf;

    ////////////////////////////////////////
    // state
    ////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        if (hdr) begin
            state_nxt = eop ? st_verdict : st_payload;  // a new sop always restarts
        end else if (word && eop) begin
            state_nxt = st_verdict;
        end else if (state == st_verdict) begin
            state_nxt = st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            count <= '0;
            ovf   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (hdr) begin
                count <= '0;
                ovf   <= buf_w.full;
            end else if (word && count <= max_len) begin
                count <= count + 1'b1;
            end
        end
    end

    // header fields
    always_ff @(posedge clk) begin
        if (hdr) begin
            dest_q <= data[hdr_dest_lo +: port_w];
            pri_q  <= data[hdr_pri_lo +: pri_w];
        end
    end

    crc32_d64 u_crc (
        .clk   (clk),
        .rst   (rst),
        .clear (hdr),
        .en    (word),
        .data  (data),
        .crc   (crc)
    );

    ////////////////////////////////////////
    // buffer and descriptor side
    ////////////////////////////////////////
    assign buf_w.en      = word && !ovf && (count < max_len);  // stop past the limit
    assign buf_w.data    = data;
    assign buf_w.commit  = keep;
    assign buf_w.discard = ((state == st_verdict) && !keep)
                         || ((state == st_payload) && hdr);  // cut short by sop

    assign desc_push = keep;
    assign drop      = buf_w.discard;
    assign desc      = '{dest: dest_q, pri: pri_q, crc: crc, nwords: count};

    a_eop_vld: assert property (
        @(posedge clk) disable iff (!rst)
        eop |-> vld
    );

endmodule

// ==== src/frame_emitter.sv ====
module frame_emitter #(
    parameter int PORT_ID = 0
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           desc_empty,
    input  ingress_pkg::desc_t             desc,
    output logic                           desc_pop,
    output logic                           rd_en,
    input  logic [ingress_pkg::data_w-1:0] rd_data,
    output logic [ingress_pkg::out_w-1:0]  out_data,
    output logic                           out_vld,
    output logic                           out_sof
);
    import ingress_pkg::*;

    localparam logic [port_w-1:0] src_tag = port_w'(PORT_ID);

    logic [len_w-1:0]  left;        // data words still to send
    logic [port_w-1:0] dest_q;
    logic              start;

    // wait one idle output cycle after the last data word
    assign start    = (left == '0) && !out_vld && !desc_empty;
    assign desc_pop = start;

    // reads run one word ahead of the output
    assign rd_en = start || (left > len_w'(1));

    always_ff @(posedge clk) begin
        if (start) begin
            dest_q <= desc.dest;
        end
    end

    ////////////////////////////////////////
    // output word
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            left     <= '0;
            out_vld  <= 1'b0;
            out_sof  <= 1'b0;
            out_data <= '0;
        end else begin
            out_sof  <= start;
            out_vld  <= start || (left != '0);
            out_data <= '0;
            if (start) begin
                left                             <= desc.nwords;
                out_data[out_valid_bit]          <= 1'b1;
                out_data[out_dest_lo +: port_w]  <= desc.dest;
                out_data[out_src_lo +: port_w]   <= src_tag;
                out_data[out_pri_lo +: pri_w]    <= desc.pri;
                out_data[out_crc_lo +: crc_w]    <= desc.crc;
            end else if (left != '0) begin
                left                             <= left - 1'b1;
                out_data[out_valid_bit]          <= 1'b1;
                out_data[out_dest_lo +: port_w]  <= dest_q;
                out_data[out_src_lo +: port_w]   <= src_tag;
                out_data[out_pay_lo +: data_w]   <= rd_data;  // read issued last cycle
            end
        end
    end

endmodule

// ==== src/ingress_port.sv ====
module ingress_port #(
    parameter int PORT_ID    = 0,
    parameter int MIN_WORDS  = 2,
    parameter int MAX_WORDS  = 32,
    parameter int BUF_DEPTH  = 128,
    parameter int DESC_DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_sop,
    input  logic                           in_eop,
    input  logic                           in_vld,
    input  logic [ingress_pkg::data_w-1:0] in_data,
    output logic                           full,
    output logic                           almost_full,
    output logic                           drop,
    output logic [ingress_pkg::out_w-1:0]  out_data,
    output logic                           out_vld,
    output logic                           out_sof
);
    import ingress_pkg::*;

    buf_wr_if buf_if ();

    desc_t             push_desc;
    desc_t             pop_desc;
    logic              desc_push;
    logic              desc_pop;
    logic              desc_empty;
    logic              rd_en;
    logic [data_w-1:0] rd_data;

    assign full        = buf_if.full;
    assign almost_full = buf_if.almost_full;

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////
    pkt_receiver #(
        .MIN_WORDS (MIN_WORDS),
        .MAX_WORDS (MAX_WORDS)
    ) u_rx (
        .clk       (clk),
        .rst       (rst),
        .sop       (in_sop),
        .eop       (in_eop),
        .vld       (in_vld),
        .data      (in_data),
        .buf_w     (buf_if.src),
        .desc_push (desc_push),
        .desc      (push_desc),
        .drop      (drop)
    );

    pkt_buffer #(
        .BUF_DEPTH (BUF_DEPTH),
        .MAX_WORDS (MAX_WORDS)
    ) u_buf (
        .clk     (clk),
        .rst     (rst),
        .wr      (buf_if.sink),
        .rd_en   (rd_en),
        .rd_data (rd_data)
    );

    desc_fifo #(
        .DESC_DEPTH (DESC_DEPTH)
    ) u_desc (
        .clk       (clk),
        .rst       (rst),
        .push      (desc_push),
        .push_desc (push_desc),
        .pop       (desc_pop),
        .pop_desc  (pop_desc),
        .empty     (desc_empty)
    );

    // output side toward the fabric
    frame_emitter #(
        .PORT_ID (PORT_ID)
    ) u_tx (
        .clk        (clk),
        .rst        (rst),
        .desc_empty (desc_empty),
        .desc       (pop_desc),
        .desc_pop   (desc_pop),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .out_data   (out_data),
        .out_vld    (out_vld),
        .out_sof    (out_sof)
    );

endmodule

// ==== tb/tb_ingress_port.sv ====
module tb_ingress_port;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_pkts = 64;
    localparam int rec_w    = 6;            // fields per vector record
    localparam logic [3:0] port_id = 4'd0;

    logic        clk;
    logic        rst;
    logic        in_sop;
    logic        in_eop;
    logic        in_vld;
    logic [63:0] in_data;
    logic        full;
    logic        almost_full;
    logic        drop;
    logic [72:0] out_data;
    logic        out_vld;
    logic        out_sof;

    logic [31:0] vec [rec_w*max_pkts];
    logic [73:0] exp_q [$];                 // {sof, fabric word}
    logic [31:0] rng;
    logic        burst;
    logic        prev_vld = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          drops_seen = 0;
    int          exp_drops = 0;
    int          cycles = 0;
    int          limit = 0;

    ingress_port dut_i (
        .clk         (clk),
        .rst         (rst),
        .in_sop      (in_sop),
        .in_eop      (in_eop),
        .in_vld      (in_vld),
        .in_data     (in_data),
        .full        (full),
        .almost_full (almost_full),
        .drop        (drop),
        .out_data    (out_data),
        .out_vld     (out_vld),
        .out_sof     (out_sof)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] r;
        r = x ^ (x << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // ethernet crc, one byte at a time, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c ^ {24'h0, b};
        for (int k = 0; k < 8; k++) begin
            r = r[0] ? ((r >> 1) ^ 32'hedb88320) : (r >> 1);
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [73:0] got, input logic [73:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // no gaps during a burst until the buffer fills up
    task automatic pick_gap(output int gap);
        rng = xorshift(rng);
        if (burst && !almost_full) begin
            gap = 0;
        end else begin
            gap = rng[2] ? 0 : int'(rng[1:0]);
        end
    endtask

    task automatic drive_word(input logic s, input logic e, input logic [63:0] d, input int gap);
        in_sop  = s;
        in_eop  = e;
        in_vld  = 1'b1;
        in_data = d;
        @(posedge clk);
        #1;
        in_sop = 1'b0;
        in_eop = 1'b0;
        in_vld = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////////////////////////
    // one packet from the vector file
    ////////////////////////////////////////
    task automatic send_packet(input int idx);
        logic [31:0] mode;
        logic [31:0] s;
        logic [3:0]  dest;
        logic [2:0]  pri;
        logic        keep;
        logic [31:0] crc;
        logic [63:0] w;
        logic [63:0] pay [$];
        int          n;
        int          gap;
        mode  = vec[idx*rec_w];
        dest  = vec[idx*rec_w+1][3:0];
        pri   = vec[idx*rec_w+2][2:0];
        n     = int'(vec[idx*rec_w+3]);
        keep  = vec[idx*rec_w+4][0];
        s     = vec[idx*rec_w+5];
        burst = (mode == 2);
        crc   = '1;
        for (int i = 0; i < n; i++) begin
            s = xorshift(s);
            w[63:32] = s;
            s = xorshift(s);
            w[31:0] = s;
            for (int b = 0; b < 8; b++) begin
                crc = crc_byte(crc, w[8*b +: 8]);
            end
            pay.push_back(w);
        end
        // expected words go in before the packet can reach the output
        if (keep) begin
            exp_q.push_back({1'b1, 29'h0, ~crc, pri, port_id, dest, 1'b1});
            foreach (pay[i]) begin
                exp_q.push_back({1'b0, pay[i], port_id, dest, 1'b1});
            end
        end else begin
            exp_drops++;
        end
        while (full) begin
            @(posedge clk);
            #1;
        end
        rng = xorshift(rng);
        pick_gap(gap);
        drive_word(1'b1, 1'b0, {rng, 25'h0, pri, dest}, gap);
        for (int i = 0; i < n; i++) begin
            pick_gap(gap);
            drive_word(1'b0, (mode != 1) && (i == n - 1), pay[i], gap);   // cut: no eop
        end
    endtask

    ////////////////////////////////////////
    // output scoreboard
    ////////////////////////////////////////
    always @(negedge clk) begin
        logic [73:0] e;
        if (rst) begin
            if (drop) drops_seen++;
            if (out_vld) begin
                if (prev_vld && out_sof) begin
                    errors++;
                    $display("new packet started without an idle cycle");
                end
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("output word appeared with no packet expected");
                end else begin
                    e = exp_q.pop_front();
                    check("out_data", 74'(out_data), 74'(e[72:0]));
                    check("out_sof", 74'(out_sof), 74'(e[73]));
                end
            end else if (prev_vld && exp_q.size() != 0 && !exp_q[0][73]) begin
                errors++;
                $display("output stopped in the middle of a packet");
            end
            prev_vld = out_vld;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, %0d words never came out", cycles, exp_q.size());
            $display("errors %0d of %0d checks", errors, checks);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int n_pkts;
        int total;
        rst     = 1'b0;
        in_sop  = 1'b0;
        in_eop  = 1'b0;
        in_vld  = 1'b0;
        in_data = '0;
        burst   = 1'b0;
        rng     = 32'hc1a142a6;
        foreach (vec[i]) vec[i] = 32'hf;    // end marker if the file is short
        $readmemh("tb/ingress_vectors.txt", vec);
        n_pkts = 0;
        total  = 0;
        while (n_pkts < max_pkts && vec[n_pkts*rec_w] != 32'hf) begin
            total += int'(vec[n_pkts*rec_w+3]) + 1;
            n_pkts++;
        end
        if (n_pkts == 0) begin
            errors++;
            $display("no packets read from the vector file");
        end
        limit = 4 * total + 500;
        repeat (16) @(posedge clk);
        #1 rst = 1'b1;
        @(negedge clk);                     // idle state after reset
        check("out_vld", 74'(out_vld), 74'(0));
        check("out_sof", 74'(out_sof), 74'(0));
        check("drop", 74'(drop), 74'(0));
        check("full", 74'(full), 74'(0));
        check("almost_full", 74'(almost_full), 74'(0));
        @(posedge clk);
        #1;
        for (int p = 0; p < n_pkts; p++) begin
            send_packet(p);
        end
        burst = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);         // catch stray output
        @(negedge clk);
        // everything sent or discarded, buffer back to empty
        check("full", 74'(full), 74'(0));
        check("almost_full", 74'(almost_full), 74'(0));
        check("drop count", 74'(drops_seen), 74'(exp_drops));
        $display("errors %0d of %0d checks, drops %0d", errors, checks, drops_seen);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
src/ingress_pkg.sv
src/buf_wr_if.sv
src/crc32_d64.sv
src/pkt_buffer.sv
src/desc_fifo.sv
src/pkt_receiver.sv
src/frame_emitter.sv
src/ingress_port.sv
tb/tb_ingress_port.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_ingress_port -f src.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

// ==== tb/ingress_vectors.txt ====
// packet records: mode dest pri nwords keep payload_seed
// mode 0 normal, 1 cut short by the next sop, 2 back-to-back burst, f ends the list
0 3 5 02 1 1f2e3d4c   // shortest legal length
0 7 1 20 1 9a0b1c2d   // longest legal length
0 2 0 01 0 55aa0f0f   // one word short
0 9 6 21 0 0badcafe   // one word too long
0 c 2 05 1 13572468
1 4 3 03 0 2468ace0   // cut short
0 4 3 06 1 7e7e1234   // must survive the cut
0 0 7 01 0 31415926
1 a 7 0a 0 27182818
0 b 4 04 1 5eed0001
2 1 1 0c 1 a1b2c3d4
2 2 2 10 1 0c0ffee5
2 3 3 08 1 600dbeef
2 5 0 14 1 12345678
2 6 4 0b 1 87654321
2 8 6 10 1 deadf00d
0 e 5 03 1 abad1dea
0 f 0 02 1 c0ffee11
f 0 0 0 0 0
